// ==== src/mesh_pkg.sv ====
package mesh_pkg;

   localparam int x_cord_width = 2;
   localparam int y_cord_width = 2;
   localparam int addr_width   = 4;
   localparam int data_width   = 32;
   localparam int num_ports    = 5;

   // router port order, proc is the local socket
   typedef enum logic [2:0]
   {
      proc  = 3'd0,
      west  = 3'd1,
      east  = 3'd2,
      north = 3'd3,
      south = 3'd4
   } dir_e;

   typedef enum logic [1:0]
   {
      store     = 2'd0,
      load      = 2'd1,
      csr_write = 2'd2
   } opcode_e;

   typedef enum logic [1:0]
   {
      idle   = 2'd0,
      access = 2'd1,
      reply  = 2'd2
   } socket_state_e;

   // destination first, the router reads it from the top bits
   typedef struct packed
   {
      logic [x_cord_width-1:0] dst_x;
      logic [y_cord_width-1:0] dst_y;
      logic [x_cord_width-1:0] src_x;
      logic [y_cord_width-1:0] src_y;
      opcode_e                 opcode;
      logic [addr_width-1:0]   addr;
      logic [data_width-1:0]   data;
   } fwd_packet_s;

   typedef struct packed
   {
      logic [x_cord_width-1:0] dst_x;
      logic [y_cord_width-1:0] dst_y;
      logic [data_width-1:0]   data;
   } rev_packet_s;

   typedef struct packed
   {
      logic        v;
      fwd_packet_s pkt;
   } fwd_link_s;

   typedef struct packed
   {
      logic        v;
      rev_packet_s pkt;
   } rev_link_s;

   localparam int fwd_width = $bits(fwd_packet_s);
   localparam int rev_width = $bits(rev_packet_s);

   // load reads the store count here, csr_write ignores the address
   localparam logic [addr_width-1:0] csr_addr = {addr_width{1'b1}};

endpackage

// ==== src/mesh_route_fifo.sv ====
`timescale 1ns/10ps

module mesh_route_fifo
#(
   parameter int width_p = 8
)
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               v_i,
   input  logic [width_p-1:0] data_i,
   output logic               ready_o,
   output logic               v_o,
   output logic [width_p-1:0] data_o,
   input  logic               yumi_i
);

   logic [1:0][width_p-1:0] mem_q;
   logic                    wptr_q;
   logic                    rptr_q;
   logic [1:0]              count_q;
   logic                    enq;

   assign ready_o = count_q != 2'd2;
   assign v_o     = count_q != 2'd0;
   assign data_o  = mem_q[rptr_q];
   assign enq     = v_i && ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_q  <= 1'b0;
         rptr_q  <= 1'b0;
         count_q <= 2'd0;
      end
      else
      begin
         if (enq)
            wptr_q <= ~wptr_q;
         if (yumi_i)
            rptr_q <= ~rptr_q;
         // simultaneous enq and deq leaves the count alone
         if (enq && !yumi_i)
            count_q <= count_q + 2'd1;
         else if (!enq && yumi_i)
            count_q <= count_q - 2'd1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_q[wptr_q] <= data_i;
   end

endmodule

// ==== src/mesh_router.sv ====
`timescale 1ns/10ps

module mesh_router
#(
   parameter int width_p = 8
)
(
   input  logic                                              clk_i,
   input  logic                                              rst_n_i,
   input  logic [mesh_pkg::num_ports-1:0]                    v_i,
   input  logic [mesh_pkg::num_ports-1:0][width_p-1:0]       data_i,
   output logic [mesh_pkg::num_ports-1:0]                    ready_o,
   output logic [mesh_pkg::num_ports-1:0]                    v_o,
   output logic [mesh_pkg::num_ports-1:0][width_p-1:0]       data_o,
   input  logic [mesh_pkg::num_ports-1:0]                    ready_i,
   input  logic [mesh_pkg::x_cord_width-1:0]                 my_x_i,
   input  logic [mesh_pkg::y_cord_width-1:0]                 my_y_i
);

   logic [mesh_pkg::num_ports-1:0]                    head_v;
   logic [mesh_pkg::num_ports-1:0][width_p-1:0]       head_data;
   logic [mesh_pkg::num_ports-1:0]                    yumi;
   mesh_pkg::dir_e [mesh_pkg::num_ports-1:0]          head_dir;
   mesh_pkg::dir_e [mesh_pkg::num_ports-1:0]          grant;
   mesh_pkg::dir_e [mesh_pkg::num_ports-1:0]          ptr_q;
   logic [mesh_pkg::num_ports-1:0]                    grant_v;

   for (genvar i = 0; i < mesh_pkg::num_ports; i++)
   begin : g_in
      mesh_route_fifo #(.width_p(width_p)) fifo
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (v_i[i]),
         .data_i  (data_i[i]),
         .ready_o (ready_o[i]),
         .v_o     (head_v[i]),
         .data_o  (head_data[i]),
         .yumi_i  (yumi[i])
      );
   end

   // XY routing, x is resolved first
   always_comb
   begin
      logic [mesh_pkg::x_cord_width-1:0] dst_x;
      logic [mesh_pkg::y_cord_width-1:0] dst_y;
      for (int i = 0; i < mesh_pkg::num_ports; i++)
      begin
         dst_x = head_data[i][width_p-1 -: mesh_pkg::x_cord_width];
         dst_y = head_data[i][width_p-1-mesh_pkg::x_cord_width -: mesh_pkg::y_cord_width];
         if (dst_x > my_x_i)
            head_dir[i] = mesh_pkg::east;
         else if (dst_x < my_x_i)
            head_dir[i] = mesh_pkg::west;
         else if (dst_y > my_y_i)
            head_dir[i] = mesh_pkg::south;
         else if (dst_y < my_y_i)
            head_dir[i] = mesh_pkg::north;
         else
            head_dir[i] = mesh_pkg::proc;
      end
   end

   // round robin search starting at the pointer
   always_comb
   begin
      int idx;
      for (int o = 0; o < mesh_pkg::num_ports; o++)
      begin
         grant_v[o] = 1'b0;
         grant[o]   = ptr_q[o];
         for (int k = 0; k < mesh_pkg::num_ports; k++)
         begin
            idx = int'(ptr_q[o]) + k;
            if (idx >= mesh_pkg::num_ports)
               idx = idx - mesh_pkg::num_ports;
            if (!grant_v[o] && head_v[idx] && head_dir[idx] == mesh_pkg::dir_e'(o))
            begin
               grant_v[o] = 1'b1;
               grant[o]   = mesh_pkg::dir_e'(idx);
            end
         end
      end
   end

   always_comb
   begin
      for (int i = 0; i < mesh_pkg::num_ports; i++)
      begin
         yumi[i] = 1'b0;
         for (int o = 0; o < mesh_pkg::num_ports; o++)
            if (grant_v[o] && ready_i[o] && grant[o] == mesh_pkg::dir_e'(i))
               yumi[i] = 1'b1;
      end
   end

   for (genvar o = 0; o < mesh_pkg::num_ports; o++)
   begin : g_out
      assign v_o[o]    = grant_v[o];
      assign data_o[o] = head_data[grant[o]];
   end

   // a stalled output parks the pointer on its winner so the grant holds
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         ptr_q <= {mesh_pkg::num_ports{mesh_pkg::proc}};
      else
      begin
         for (int o = 0; o < mesh_pkg::num_ports; o++)
         begin
            if (grant_v[o] && !ready_i[o])
               ptr_q[o] <= grant[o];
            else if (grant_v[o])
               ptr_q[o] <= (grant[o] == mesh_pkg::south) ? mesh_pkg::proc
                                                         : mesh_pkg::dir_e'(grant[o] + 3'd1);
         end
      end
   end

endmodule

// ==== src/store_bank.sv ====
`timescale 1ns/10ps

module store_bank
(
   input  logic                            clk_i,
   input  logic                            we_i,
   input  logic                            re_i,
   input  logic [mesh_pkg::addr_width-1:0] addr_i,
   input  logic [mesh_pkg::data_width-1:0] wdata_i,
   output logic [mesh_pkg::data_width-1:0] rdata_o
);

   logic [mesh_pkg::data_width-1:0] mem_q [2**mesh_pkg::addr_width];

   always_ff @(posedge clk_i)
   begin
      if (we_i)
         mem_q[addr_i] <= wdata_i;
   end

   // read data holds until the next read strobe
   always_ff @(posedge clk_i)
   begin
      if (re_i)
         rdata_o <= mem_q[addr_i];
   end

endmodule

// ==== src/store_counter.sv ====
`timescale 1ns/10ps

module store_counter
(
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            store_done_i,
   input  logic                            unfreeze_i,
   output logic [mesh_pkg::data_width-1:0] count_o,
   output logic                            freeze_o
);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         count_o  <= '0;
         freeze_o <= 1'b1;
      end
      else
      begin
         if (store_done_i)
            count_o <= count_o + 1'b1;
         // only cleared, nothing sets it again before reset
         if (unfreeze_i)
            freeze_o <= 1'b0;
      end
   end

endmodule

// ==== src/socket_ctrl.sv ====
`timescale 1ns/10ps

module socket_ctrl
(
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  mesh_pkg::fwd_link_s             req_link_i,
   output logic                            req_ready_o,
   output mesh_pkg::rev_link_s             rsp_link_o,
   input  logic                            rsp_ready_i,
   input  logic                            freeze_i,
   output logic                            bank_we_o,
   output logic                            bank_re_o,
   output logic [mesh_pkg::addr_width-1:0] bank_addr_o,
   output logic [mesh_pkg::data_width-1:0] bank_wdata_o,
   input  logic [mesh_pkg::data_width-1:0] bank_rdata_i,
   input  logic [mesh_pkg::data_width-1:0] count_i,
   output logic                            store_done_o,
   output logic                            unfreeze_o
);

   mesh_pkg::socket_state_e state_q;
   mesh_pkg::fwd_packet_s   req_q;
   logic                    served;
   logic                    csr_load;
   logic                    in_access;

   // frozen socket still takes control writes
   assign served    = !freeze_i || req_q.opcode == mesh_pkg::csr_write;
   assign csr_load  = req_q.opcode == mesh_pkg::load && req_q.addr == mesh_pkg::csr_addr;
   assign in_access = state_q == mesh_pkg::access;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         state_q <= mesh_pkg::idle;
      else
      begin
         case (state_q)
            mesh_pkg::idle:
               if (req_link_i.v)
                  state_q <= mesh_pkg::access;
            mesh_pkg::access:
               state_q <= mesh_pkg::reply;
            mesh_pkg::reply:
               if (rsp_ready_i)
                  state_q <= mesh_pkg::idle;
            default:
               state_q <= mesh_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (req_ready_o && req_link_i.v)
         req_q <= req_link_i.pkt;
   end

   assign req_ready_o  = state_q == mesh_pkg::idle;
   assign bank_we_o    = in_access && served && req_q.opcode == mesh_pkg::store;
   assign bank_re_o    = in_access && served && req_q.opcode == mesh_pkg::load && !csr_load;
   assign bank_addr_o  = req_q.addr;
   assign bank_wdata_o = req_q.data;
   assign store_done_o = bank_we_o;
   assign unfreeze_o   = in_access && req_q.opcode == mesh_pkg::csr_write && req_q.data == '0;

   // reply goes back to the requester
   always_comb
   begin
      rsp_link_o.v         = state_q == mesh_pkg::reply;
      rsp_link_o.pkt.dst_x = req_q.src_x;
      rsp_link_o.pkt.dst_y = req_q.src_y;
      if (!served)
         rsp_link_o.pkt.data = '1;
      else if (csr_load)
         rsp_link_o.pkt.data = count_i;
      else if (req_q.opcode == mesh_pkg::load)
         rsp_link_o.pkt.data = bank_rdata_i;
      else
         rsp_link_o.pkt.data = '0;
   end

endmodule

// ==== src/mesh_socket.sv ====
`timescale 1ns/10ps

module mesh_socket
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  mesh_pkg::fwd_link_s req_link_i,
   output logic                req_ready_o,
   output mesh_pkg::rev_link_s rsp_link_o,
   input  logic                rsp_ready_i,
   output logic                freeze_o
);

   logic                            bank_we;
   logic                            bank_re;
   logic [mesh_pkg::addr_width-1:0] bank_addr;
   logic [mesh_pkg::data_width-1:0] bank_wdata;
   logic [mesh_pkg::data_width-1:0] bank_rdata;
   logic [mesh_pkg::data_width-1:0] count;
   logic                            store_done;
   logic                            unfreeze;

   socket_ctrl ctrl
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_link_i   (req_link_i),
      .req_ready_o  (req_ready_o),
      .rsp_link_o   (rsp_link_o),
      .rsp_ready_i  (rsp_ready_i),
      .freeze_i     (freeze_o),
      .bank_we_o    (bank_we),
      .bank_re_o    (bank_re),
      .bank_addr_o  (bank_addr),
      .bank_wdata_o (bank_wdata),
      .bank_rdata_i (bank_rdata),
      .count_i      (count),
      .store_done_o (store_done),
      .unfreeze_o   (unfreeze)
   );

   store_bank bank
   (
      .clk_i   (clk_i),
      .we_i    (bank_we),
      .re_i    (bank_re),
      .addr_i  (bank_addr),
      .wdata_i (bank_wdata),
      .rdata_o (bank_rdata)
   );

   store_counter counter
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .store_done_i (store_done),
      .unfreeze_i   (unfreeze),
      .count_o      (count),
      .freeze_o     (freeze_o)
   );

endmodule

// ==== src/mesh_node.sv ====
`timescale 1ns/10ps

module mesh_node
(
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   input  mesh_pkg::fwd_link_s [mesh_pkg::num_ports-2:0] fwd_link_i,
   output logic [mesh_pkg::num_ports-2:0]                fwd_ready_o,
   output mesh_pkg::fwd_link_s [mesh_pkg::num_ports-2:0] fwd_link_o,
   input  logic [mesh_pkg::num_ports-2:0]                fwd_ready_i,
   input  mesh_pkg::rev_link_s [mesh_pkg::num_ports-2:0] rev_link_i,
   output logic [mesh_pkg::num_ports-2:0]                rev_ready_o,
   output mesh_pkg::rev_link_s [mesh_pkg::num_ports-2:0] rev_link_o,
   input  logic [mesh_pkg::num_ports-2:0]                rev_ready_i,
   input  logic [mesh_pkg::x_cord_width-1:0]             my_x_i,
   input  logic [mesh_pkg::y_cord_width-1:0]             my_y_i,
   output logic                                          freeze_o
);

   logic [mesh_pkg::num_ports-1:0]                          fwd_v_li, fwd_ready_lo;
   logic [mesh_pkg::num_ports-1:0]                          fwd_v_lo, fwd_ready_li;
   logic [mesh_pkg::num_ports-1:0][mesh_pkg::fwd_width-1:0] fwd_data_li, fwd_data_lo;
   logic [mesh_pkg::num_ports-1:0]                          rev_v_li, rev_ready_lo;
   logic [mesh_pkg::num_ports-1:0]                          rev_v_lo, rev_ready_li;
   logic [mesh_pkg::num_ports-1:0][mesh_pkg::rev_width-1:0] rev_data_li, rev_data_lo;
   mesh_pkg::fwd_link_s                                     sock_req;
   mesh_pkg::rev_link_s                                     sock_rsp;

   // external port k-1 is router port k
   for (genvar k = 1; k < mesh_pkg::num_ports; k++)
   begin : g_ext
      assign fwd_v_li[k]         = fwd_link_i[k-1].v;
      assign fwd_data_li[k]      = fwd_link_i[k-1].pkt;
      assign fwd_ready_o[k-1]    = fwd_ready_lo[k];
      assign fwd_link_o[k-1].v   = fwd_v_lo[k];
      assign fwd_link_o[k-1].pkt = fwd_data_lo[k];
      assign fwd_ready_li[k]     = fwd_ready_i[k-1];
      assign rev_v_li[k]         = rev_link_i[k-1].v;
      assign rev_data_li[k]      = rev_link_i[k-1].pkt;
      assign rev_ready_o[k-1]    = rev_ready_lo[k];
      assign rev_link_o[k-1].v   = rev_v_lo[k];
      assign rev_link_o[k-1].pkt = rev_data_lo[k];
      assign rev_ready_li[k]     = rev_ready_i[k-1];
   end

   // socket only consumes requests and only produces replies
   assign fwd_v_li[0]     = 1'b0;
   assign fwd_data_li[0]  = '0;
   assign sock_req.v      = fwd_v_lo[0];
   assign sock_req.pkt    = fwd_data_lo[0];
   assign rev_v_li[0]     = sock_rsp.v;
   assign rev_data_li[0]  = sock_rsp.pkt;
   // replies addressed to this tile have no consumer and are sunk
   assign rev_ready_li[0] = 1'b1;

   mesh_router #(.width_p(mesh_pkg::fwd_width)) fwd_router
   (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (fwd_v_li),
      .data_i  (fwd_data_li),
      .ready_o (fwd_ready_lo),
      .v_o     (fwd_v_lo),
      .data_o  (fwd_data_lo),
      .ready_i (fwd_ready_li),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i)
   );

   mesh_router #(.width_p(mesh_pkg::rev_width)) rev_router
   (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (rev_v_li),
      .data_i  (rev_data_li),
      .ready_o (rev_ready_lo),
      .v_o     (rev_v_lo),
      .data_o  (rev_data_lo),
      .ready_i (rev_ready_li),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i)
   );

   mesh_socket socket
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_link_i  (sock_req),
      .req_ready_o (fwd_ready_li[0]),
      .rsp_link_o  (sock_rsp),
      .rsp_ready_i (rev_ready_lo[0]),
      .freeze_o    (freeze_o)
   );

endmodule

// ==== test/mesh_node_tb.sv ====
`timescale 1ns/10ps

module mesh_node_tb;

   logic                                 clk_i;
   logic                                 rst_n_i;
   mesh_pkg::fwd_link_s [3:0]            fwd_link_i;
   logic [3:0]                           fwd_ready_o;
   mesh_pkg::fwd_link_s [3:0]            fwd_link_o;
   logic [3:0]                           fwd_ready_i;
   mesh_pkg::rev_link_s [3:0]            rev_link_i;
   logic [3:0]                           rev_ready_o;
   mesh_pkg::rev_link_s [3:0]            rev_link_o;
   logic [3:0]                           rev_ready_i;
   logic [mesh_pkg::x_cord_width-1:0]    my_x_i;
   logic [mesh_pkg::y_cord_width-1:0]    my_y_i;
   logic                                 freeze_o;

   // expected packets per path indexed [input port][output port]
   mesh_pkg::fwd_packet_s fwd_exp [mesh_pkg::num_ports][mesh_pkg::num_ports][$];
   mesh_pkg::rev_packet_s rev_exp [mesh_pkg::num_ports][mesh_pkg::num_ports][$];

   logic [mesh_pkg::data_width-1:0] bank [2**mesh_pkg::addr_width];
   int                              stores;
   logic                            frozen;
   int                              ready_mode;
   int                              checks;
   int                              errors;
   int                              tests;
   int                              test_start;

   mesh_node UUT
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .fwd_link_i  (fwd_link_i),
      .fwd_ready_o (fwd_ready_o),
      .fwd_link_o  (fwd_link_o),
      .fwd_ready_i (fwd_ready_i),
      .rev_link_i  (rev_link_i),
      .rev_ready_o (rev_ready_o),
      .rev_link_o  (rev_link_o),
      .rev_ready_i (rev_ready_i),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .freeze_o    (freeze_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic check_fwd(input string name, input mesh_pkg::fwd_packet_s got,
                            input mesh_pkg::fwd_packet_s exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_rev(input string name, input mesh_pkg::rev_packet_s got,
                            input mesh_pkg::rev_packet_s exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_freeze(input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED freeze_o: got %h expected %h", got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR: %s", msg);
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR: timed out %s", msg);
      $display("Simulation FAILED");
      $finish;
   endtask

   // router port chosen by the XY rule
   function automatic int route_port(input logic [mesh_pkg::x_cord_width-1:0] x,
                                     input logic [mesh_pkg::y_cord_width-1:0] y);
      if (x > my_x_i)
         return 2;
      if (x < my_x_i)
         return 1;
      if (y > my_y_i)
         return 4;
      if (y < my_y_i)
         return 3;
      return 0;
   endfunction

   function automatic int pending();
      int n;
      n = 0;
      for (int i = 0; i < mesh_pkg::num_ports; i++)
         for (int o = 0; o < mesh_pkg::num_ports; o++)
            n += fwd_exp[i][o].size() + rev_exp[i][o].size();
      return n;
   endfunction

   // socket model applied in the order requests reach the socket
   function automatic logic [mesh_pkg::data_width-1:0] model_reply(
      input mesh_pkg::fwd_packet_s pkt);
      logic [mesh_pkg::data_width-1:0] data;
      data = '0;
      if (frozen && pkt.opcode != mesh_pkg::csr_write)
         data = '1;
      else
      begin
         case (pkt.opcode)
            mesh_pkg::store:
            begin
               bank[pkt.addr] = pkt.data;
               stores++;
            end
            mesh_pkg::load:
               data = (pkt.addr == mesh_pkg::csr_addr) ? stores : bank[pkt.addr];
            mesh_pkg::csr_write:
               if (pkt.data == '0)
                  frozen = 1'b0;
            default:
               data = '0;
         endcase
      end
      return data;
   endfunction

   // the first matching path head wins and a miss is compared to any head
   task automatic take_fwd(input int out, input mesh_pkg::fwd_packet_s got);
      int    hit;
      string name;
      hit  = -1;
      name = $sformatf("fwd_link_o[%0d].pkt", out - 1);
      for (int i = 0; i < mesh_pkg::num_ports; i++)
         if (hit < 0 && fwd_exp[i][out].size() > 0 && fwd_exp[i][out][0] == got)
            hit = i;
      if (hit >= 0)
      begin
         check_fwd(name, got, fwd_exp[hit][out][0]);
         void'(fwd_exp[hit][out].pop_front());
      end
      else
      begin
         for (int i = 0; i < mesh_pkg::num_ports; i++)
            if (hit < 0 && fwd_exp[i][out].size() > 0)
               hit = i;
         if (hit >= 0)
            check_fwd(name, got, fwd_exp[hit][out][0]);
         else
            report_error($sformatf("unexpected packet on fwd_link_o[%0d]", out - 1));
      end
   endtask

   task automatic take_rev(input int out, input mesh_pkg::rev_packet_s got);
      int    hit;
      string name;
      hit  = -1;
      name = $sformatf("rev_link_o[%0d].pkt", out - 1);
      for (int i = 0; i < mesh_pkg::num_ports; i++)
         if (hit < 0 && rev_exp[i][out].size() > 0 && rev_exp[i][out][0] == got)
            hit = i;
      if (hit >= 0)
      begin
         check_rev(name, got, rev_exp[hit][out][0]);
         void'(rev_exp[hit][out].pop_front());
      end
      else
      begin
         for (int i = 0; i < mesh_pkg::num_ports; i++)
            if (hit < 0 && rev_exp[i][out].size() > 0)
               hit = i;
         if (hit >= 0)
            check_rev(name, got, rev_exp[hit][out][0]);
         else
            report_error($sformatf("unexpected packet on rev_link_o[%0d]", out - 1));
      end
   endtask

   // outputs are settled at the falling edge
   always @(negedge clk_i)
   begin
      for (int k = 0; k < 4; k++)
      begin
         if (fwd_link_o[k].v && fwd_ready_i[k])
            take_fwd(k + 1, fwd_link_o[k].pkt);
         if (rev_link_o[k].v && rev_ready_i[k])
            take_rev(k + 1, rev_link_o[k].pkt);
      end
   end

   // 0 all ready, 1 random, 2 stalled
   task automatic drive_ready();
      forever
      begin
         @(posedge clk_i);
         if (ready_mode == 1)
         begin
            fwd_ready_i <= 4'($urandom);
            rev_ready_i <= 4'($urandom);
         end
         else if (ready_mode == 2)
         begin
            fwd_ready_i <= '0;
            rev_ready_i <= '0;
         end
         else
         begin
            fwd_ready_i <= '1;
            rev_ready_i <= '1;
         end
      end
   endtask

   // queues only change at the falling edge
   task automatic wait_drain(input string what, input int limit);
      int n;
      n = 0;
      while (pending() > 0)
      begin
         @(posedge clk_i);
         n++;
         if (n > limit)
            abort_run($sformatf("waiting for %s packets to leave", what));
      end
      @(negedge clk_i);
   endtask

   task automatic send_fwd(input int port, input mesh_pkg::fwd_packet_s pkt);
      int n;
      n = 0;
      @(posedge clk_i);
      fwd_link_i[port] <= {1'b1, pkt};
      @(negedge clk_i);
      while (!fwd_ready_o[port])
      begin
         n++;
         if (n > 200)
            abort_run($sformatf("waiting for fwd_ready_o[%0d]", port));
         @(negedge clk_i);
      end
      @(posedge clk_i);
      fwd_link_i[port].v <= 1'b0;
   endtask

   task automatic send_rev(input int port, input mesh_pkg::rev_packet_s pkt);
      int n;
      n = 0;
      @(posedge clk_i);
      rev_link_i[port] <= {1'b1, pkt};
      @(negedge clk_i);
      while (!rev_ready_o[port])
      begin
         n++;
         if (n > 200)
            abort_run($sformatf("waiting for rev_ready_o[%0d]", port));
         @(negedge clk_i);
      end
      @(posedge clk_i);
      rev_link_i[port].v <= 1'b0;
   endtask

   task automatic rand_coord(output logic [mesh_pkg::x_cord_width-1:0] x,
                             output logic [mesh_pkg::y_cord_width-1:0] y);
      do
      begin
         x = $urandom_range(0, 3);
         y = $urandom_range(0, 3);
      end
      while (x == my_x_i && y == my_y_i);
   endtask

   // a packet for another tile on a random network and port
   task automatic send_transit();
      mesh_pkg::fwd_packet_s fpkt;
      mesh_pkg::rev_packet_s rpkt;
      int                    port;
      port = $urandom_range(0, 3);
      if ($urandom_range(0, 1) == 0)
      begin
         rand_coord(fpkt.dst_x, fpkt.dst_y);
         fpkt.src_x  = $urandom_range(0, 3);
         fpkt.src_y  = $urandom_range(0, 3);
         fpkt.opcode = mesh_pkg::opcode_e'($urandom_range(0, 2));
         fpkt.addr   = $urandom_range(0, 15);
         fpkt.data   = $urandom;
         fwd_exp[port + 1][route_port(fpkt.dst_x, fpkt.dst_y)].push_back(fpkt);
         send_fwd(port, fpkt);
      end
      else
      begin
         rand_coord(rpkt.dst_x, rpkt.dst_y);
         rpkt.data = $urandom;
         rev_exp[port + 1][route_port(rpkt.dst_x, rpkt.dst_y)].push_back(rpkt);
         send_rev(port, rpkt);
      end
   endtask

   // one socket request and its reply
   task automatic send_request(input mesh_pkg::opcode_e op,
                               input logic [mesh_pkg::addr_width-1:0] addr,
                               input logic [mesh_pkg::data_width-1:0] data);
      mesh_pkg::fwd_packet_s pkt;
      mesh_pkg::rev_packet_s rsp;
      rand_coord(pkt.src_x, pkt.src_y);
      pkt.dst_x  = my_x_i;
      pkt.dst_y  = my_y_i;
      pkt.opcode = op;
      pkt.addr   = addr;
      pkt.data   = data;
      rsp.dst_x  = pkt.src_x;
      rsp.dst_y  = pkt.src_y;
      rsp.data   = model_reply(pkt);
      rev_exp[0][route_port(rsp.dst_x, rsp.dst_y)].push_back(rsp);
      send_fwd($urandom_range(0, 3), pkt);
      wait_drain("socket reply", 200);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s: %s, %0d errors", tests, name,
               (errors == test_start) ? "ok" : "failed", errors - test_start);
      test_start = errors;
   endtask

   initial
   begin
      logic [mesh_pkg::addr_width-1:0] addr_q [$];
      logic [mesh_pkg::addr_width-1:0] a;
      void'($urandom(32'h73fc_6840));
      rst_n_i     = 1'b0;
      fwd_link_i  = '0;
      rev_link_i  = '0;
      fwd_ready_i = '1;
      rev_ready_i = '1;
      my_x_i      = 2'd1;
      my_y_i      = 2'd1;
      ready_mode  = 0;
      frozen      = 1'b1;
      stores      = 0;
      checks      = 0;
      errors      = 0;
      tests       = 0;
      test_start  = 0;
      fork
         drive_ready();
      join_none
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);

      for (int k = 0; k < 4; k++)
      begin
         check_flag($sformatf("fwd_link_o[%0d].v", k), fwd_link_o[k].v, 1'b0);
         check_flag($sformatf("rev_link_o[%0d].v", k), rev_link_o[k].v, 1'b0);
         check_flag($sformatf("fwd_ready_o[%0d]", k), fwd_ready_o[k], 1'b1);
         check_flag($sformatf("rev_ready_o[%0d]", k), rev_ready_o[k], 1'b1);
      end
      check_freeze(freeze_o, 1'b1);
      end_test("reset state");

      ready_mode = 1;
      repeat (60) send_transit();
      wait_drain("transit", 2000);
      end_test("transit routing");

      repeat (4) send_request(mesh_pkg::store, $urandom_range(0, 14), $urandom);
      repeat (4) send_request(mesh_pkg::load, $urandom_range(0, 15), $urandom);
      send_request(mesh_pkg::csr_write, $urandom_range(0, 15), $urandom | 32'd1);
      check_freeze(freeze_o, frozen);
      send_request(mesh_pkg::csr_write, mesh_pkg::csr_addr, '0);
      check_freeze(freeze_o, frozen);
      // frozen stores must not have counted
      send_request(mesh_pkg::load, mesh_pkg::csr_addr, '0);
      end_test("freeze");

      repeat (12)
      begin
         a = $urandom_range(0, 14);
         send_request(mesh_pkg::store, a, $urandom);
         addr_q.push_back(a);
      end
      foreach (addr_q[i])
         send_request(mesh_pkg::load, addr_q[i], $urandom);
      end_test("store and load");

      send_request(mesh_pkg::load, mesh_pkg::csr_addr, $urandom);
      end_test("store count");

      ready_mode = 2;
      fork
         begin
            repeat (60) @(posedge clk_i);
            ready_mode <= 1;
         end
         begin
            repeat (40) send_transit();
         end
      join
      wait_drain("back-pressure", 3000);
      end_test("back-pressure");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== sources.f ====
src/mesh_pkg.sv
src/mesh_route_fifo.sv
src/mesh_router.sv
src/store_bank.sv
src/store_counter.sv
src/socket_ctrl.sv
src/mesh_socket.sv
src/mesh_node.sv
test/mesh_node_tb.sv

// ==== Bender.yml ====
package:
  name: mesh_node

sources:
  - src/mesh_pkg.sv
  - src/mesh_route_fifo.sv
  - src/mesh_router.sv
  - src/store_bank.sv
  - src/store_counter.sv
  - src/socket_ctrl.sv
  - src/mesh_socket.sv
  - src/mesh_node.sv
  - target: test
    files:
      - test/mesh_node_tb.sv
